// File: Makefile
VERILATOR ?= verilator
FLAGS     ?= --assert --timing -Wall
TOP       ?= tb_sbus2axi
FILELIST  ?= sources.f
LOG       ?= sim.log

.PHONY: lint sim clean

lint:
	$(VERILATOR) --lint-only $(FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(FLAGS) --top-module $(TOP) -f $(FILELIST)
	./obj_dir/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "FAIL: see errors above" $(LOG); then exit 1; fi
	@grep -q "PASS: all tests" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: sources.f
src/sbus_axi_pkg.sv
src/sbus_region_decode.sv
src/axi_wr_master.sv
src/axi_rd_master.sv
src/sbus2axi.sv
tests/sbus2axi_props.sv
tests/tb_sbus2axi.sv

// File: src/axi_rd_master.sv
`timescale 1ns/1ns

module axi_rd_master
	import sbus_axi_pkg::*;
#(
	parameter int addr_w = sbus_axi_pkg::addr_w,
	parameter int data_w = sbus_axi_pkg::data_w,
	parameter int id_w = sbus_axi_pkg::id_w
) (
	input  logic aclk,
	input  logic arst_n,
	// request side
	input  logic rd_req,
	input  logic [addr_w-1:0] addr,
	input  logic [2:0] size,
	input  logic [id_w-1:0] id,
	input  logic data_resp,
	input  logic wr_data_ok,
	output logic addr_ok,
	output logic data_ok,
	output logic err,
	output logic [data_w-1:0] rdata,
	// read address channel
	output logic [addr_w-1:0] araddr,
	output logic [3:0] arlen,
	output logic [2:0] arsize,
	output logic [1:0] arburst,
	output logic [id_w-1:0] arid,
	output logic arvalid,
	input  logic arready,
	// read data channel
	input  logic [data_w-1:0] rdata_i,
	input  logic [1:0] rresp,
	input  logic rlast,
	input  logic [id_w-1:0] rid,
	input  logic rvalid,
	output logic rready
);

	rd_state_e state;

	assign arlen = 4'd0;
	assign arburst = burst_incr;

	assign addr_ok = rd_req && (state == rd_idle);
	assign rready = (state == rd_data);

	// a pending write completion goes out first
	assign data_ok = (state == rd_done) && !wr_data_ok;

	always_ff @(posedge aclk or negedge arst_n) begin
		if (!arst_n) begin
			state <= rd_idle;
			arvalid <= 1'b0;
			err <= 1'b0;
		end else begin
			case (state)
				rd_idle: begin
					if (addr_ok) begin
						arvalid <= 1'b1;
						state <= rd_addr;
					end
				end
				rd_addr: begin
					if (arready) begin
						arvalid <= 1'b0;
						state <= rd_data;
					end
				end
				rd_data: begin
					// one beat, so it must be the last and carry our id
					if (rvalid) begin
						err <= (resp_e'(rresp) != resp_okay) || !rlast || (rid != arid);
						state <= rd_done;
					end
				end
				rd_done: begin
					if (data_ok && data_resp) begin
						err <= 1'b0;
						state <= rd_idle;
					end
				end
				default: state <= rd_idle;
			endcase
		end
	end

	always_ff @(posedge aclk) begin
		if (addr_ok) begin
			araddr <= addr;
			arsize <= size;
			arid <= id;
		end
		if (rready && rvalid)
			rdata <= rdata_i;
	end

endmodule

// File: src/axi_wr_master.sv
`timescale 1ns/1ns

module axi_wr_master
	import sbus_axi_pkg::*;
#(
	parameter int addr_w = sbus_axi_pkg::addr_w,
	parameter int data_w = sbus_axi_pkg::data_w,
	parameter int id_w = sbus_axi_pkg::id_w,
	localparam int strb_w = data_w / 8
) (
	input  logic aclk,
	input  logic arst_n,
	// request side
	input  logic wr_req,
	input  logic [addr_w-1:0] addr,
	input  logic [data_w-1:0] wdata,
	input  logic [strb_w-1:0] wmask,
	input  logic [2:0] size,
	input  logic [id_w-1:0] id,
	input  logic data_resp,
	output logic addr_ok,
	output logic data_ok,
	output logic err,
	output logic writing,
	output logic [addr_w-1:0] last_write_address,
	// write address channel
	output logic [addr_w-1:0] awaddr,
	output logic [3:0] awlen,
	output logic [2:0] awsize,
	output logic [1:0] awburst,
	output logic [id_w-1:0] awid,
	output logic awvalid,
	input  logic awready,
	// write data channel
	output logic [data_w-1:0] wdata_o,
	output logic [strb_w-1:0] wstrb,
	output logic wlast,
	output logic [id_w-1:0] wid,
	output logic wvalid,
	input  logic wready,
	// write response channel
	input  logic [1:0] bresp,
	input  logic [id_w-1:0] bid,
	input  logic bvalid,
	output logic bready
);

	wr_state_e state;
	logic aw_done;
	logic w_done;
	logic aw_fin;
	logic w_fin;

	// single beat only
	assign awlen = 4'd0;
	assign awburst = burst_incr;
	assign wlast = 1'b1;
	assign wid = awid;

	assign addr_ok = wr_req && (state == wr_idle);
	assign bready = (state == wr_resp);
	assign data_ok = (state == wr_done);
	assign writing = (state != wr_idle);

	// aw and w may finish in either order
	assign aw_fin = aw_done || (awvalid && awready);
	assign w_fin = w_done || (wvalid && wready);

	always_ff @(posedge aclk or negedge arst_n) begin
		if (!arst_n) begin
			state <= wr_idle;
			awvalid <= 1'b0;
			wvalid <= 1'b0;
			aw_done <= 1'b0;
			w_done <= 1'b0;
			err <= 1'b0;
			last_write_address <= '0;
		end else begin
			case (state)
				wr_idle: begin
					if (addr_ok) begin
						awvalid <= 1'b1;
						wvalid <= 1'b1;
						aw_done <= 1'b0;
						w_done <= 1'b0;
						last_write_address <= addr;
						state <= wr_addr_data;
					end
				end
				wr_addr_data: begin
					if (awvalid && awready) begin
						awvalid <= 1'b0;
						aw_done <= 1'b1;
					end
					if (wvalid && wready) begin
						wvalid <= 1'b0;
						w_done <= 1'b1;
					end
					if (aw_fin && w_fin)
						state <= wr_resp;
				end
				wr_resp: begin
					// a stray id counts as a failed write
					if (bvalid) begin
						err <= (resp_e'(bresp) != resp_okay) || (bid != awid);
						state <= wr_done;
					end
				end
				wr_done: begin
					if (data_resp) begin
						err <= 1'b0;
						state <= wr_idle;
					end
				end
				default: state <= wr_idle;
			endcase
		end
	end

	// request payload, held for the whole transaction
	always_ff @(posedge aclk) begin
		if (addr_ok) begin
			awaddr <= addr;
			awsize <= size;
			awid <= id;
			wdata_o <= wdata;
			wstrb <= wmask;
		end
	end

endmodule

// File: src/sbus2axi.sv
`timescale 1ns/1ns

module sbus2axi
	import sbus_axi_pkg::*;
#(
	parameter int addr_w = sbus_axi_pkg::addr_w,
	parameter int data_w = sbus_axi_pkg::data_w,
	parameter int id_w = sbus_axi_pkg::id_w,
	localparam int strb_w = data_w / 8
) (
	input  logic aclk,
	input  logic arst_n,
	// ====================
	// memory bus
	// ====================
	input  logic mem_req,
	input  logic mem_wen,
	input  logic mem_ren,
	input  logic [addr_w-1:0] mem_address,
	input  logic [data_w-1:0] mem_wdata,
	input  logic [strb_w-1:0] mem_wmask,
	input  logic [2:0] mem_size,
	input  logic [match_id_w-1:0] match_id,
	output logic mem_addr_ok,
	output logic mem_data_ok,
	output logic [data_w-1:0] mem_rdata,
	output logic mem_err,
	input  logic mem_data_resp,
	output logic writing,
	output logic [addr_w-1:0] last_write_address,
	// ====================
	// axi master
	// ====================
	output logic [addr_w-1:0] awaddr,
	output logic [3:0] awlen,
	output logic [2:0] awsize,
	output logic [1:0] awburst,
	output logic [id_w-1:0] awid,
	output logic awvalid,
	input  logic awready,
	output logic [data_w-1:0] wdata,
	output logic [strb_w-1:0] wstrb,
	output logic wlast,
	output logic [id_w-1:0] wid,
	output logic wvalid,
	input  logic wready,
	input  logic [1:0] bresp,
	input  logic [id_w-1:0] bid,
	input  logic bvalid,
	output logic bready,
	output logic [addr_w-1:0] araddr,
	output logic [3:0] arlen,
	output logic [2:0] arsize,
	output logic [1:0] arburst,
	output logic [id_w-1:0] arid,
	output logic arvalid,
	input  logic arready,
	input  logic [data_w-1:0] rdata,
	input  logic [1:0] rresp,
	input  logic rlast,
	input  logic [id_w-1:0] rid,
	input  logic rvalid,
	output logic rready
);

	logic [addr_w-1:0] remap_addr;
	logic [id_w-1:0] axi_id;
	logic wr_req;
	logic rd_req;
	logic wr_addr_ok;
	logic rd_addr_ok;
	logic wr_data_ok;
	logic rd_data_ok;
	logic wr_err;
	logic rd_err;

	// write wins when both enables are set
	assign wr_req = mem_req && mem_wen;
	assign rd_req = mem_req && mem_ren && !mem_wen;

	assign mem_addr_ok = wr_addr_ok || rd_addr_ok;
	assign mem_data_ok = wr_data_ok || rd_data_ok;
	assign mem_err = wr_data_ok ? wr_err : rd_err;

	sbus_region_decode u_decode (
		.mem_address(mem_address),
		.match_id(match_id),
		.remap_addr(remap_addr),
		.axi_id(axi_id)
	);

	axi_wr_master #(
		.addr_w(addr_w),
		.data_w(data_w),
		.id_w(id_w)
	) u_wr (
		.aclk(aclk),
		.arst_n(arst_n),
		.wr_req(wr_req),
		.addr(remap_addr),
		.wdata(mem_wdata),
		.wmask(mem_wmask),
		.size(mem_size),
		.id(axi_id),
		.data_resp(mem_data_resp),
		.addr_ok(wr_addr_ok),
		.data_ok(wr_data_ok),
		.err(wr_err),
		.writing(writing),
		.last_write_address(last_write_address),
		.awaddr(awaddr),
		.awlen(awlen),
		.awsize(awsize),
		.awburst(awburst),
		.awid(awid),
		.awvalid(awvalid),
		.awready(awready),
		.wdata_o(wdata),
		.wstrb(wstrb),
		.wlast(wlast),
		.wid(wid),
		.wvalid(wvalid),
		.wready(wready),
		.bresp(bresp),
		.bid(bid),
		.bvalid(bvalid),
		.bready(bready)
	);

	axi_rd_master #(
		.addr_w(addr_w),
		.data_w(data_w),
		.id_w(id_w)
	) u_rd (
		.aclk(aclk),
		.arst_n(arst_n),
		.rd_req(rd_req),
		.addr(remap_addr),
		.size(mem_size),
		.id(axi_id),
		.data_resp(mem_data_resp),
		.wr_data_ok(wr_data_ok),
		.addr_ok(rd_addr_ok),
		.data_ok(rd_data_ok),
		.err(rd_err),
		.rdata(mem_rdata),
		.araddr(araddr),
		.arlen(arlen),
		.arsize(arsize),
		.arburst(arburst),
		.arid(arid),
		.arvalid(arvalid),
		.arready(arready),
		.rdata_i(rdata),
		.rresp(rresp),
		.rlast(rlast),
		.rid(rid),
		.rvalid(rvalid),
		.rready(rready)
	);

endmodule

// File: src/sbus_axi_pkg.sv
package sbus_axi_pkg;

	// ====================
	// bus widths
	// ====================
	localparam int addr_w = 32;
	localparam int data_w = 32;
	localparam int id_w = 6;
	localparam int match_id_w = 3;
	localparam int region_w = 3;
	localparam int strb_w = data_w / 8;

	// ====================
	// axi encodings
	// ====================
	typedef enum logic [1:0] {
		burst_fixed = 2'b00,
		burst_incr = 2'b01,
		burst_wrap = 2'b10
	} burst_e;

	typedef enum logic [1:0] {
		resp_okay = 2'b00,
		resp_exokay = 2'b01,
		resp_slverr = 2'b10,
		resp_decerr = 2'b11
	} resp_e;

	// region code, lower bits of the axi id
	typedef enum logic [region_w-1:0] {
		region_none = 3'b000,
		region_mem = 3'b001,
		region_timer = 3'b011,
		region_gpio = 3'b111
	} region_e;

	// top address nibble of each peripheral
	localparam logic [3:0] region_mem0_nib = 4'h0;
	localparam logic [3:0] region_mem1_nib = 4'h1;
	localparam logic [3:0] region_timer_nib = 4'h2;
	localparam logic [3:0] region_gpio_nib = 4'h4;

	// ====================
	// channel master states
	// ====================
	typedef enum logic [1:0] {
		wr_idle,
		wr_addr_data,
		wr_resp,
		wr_done
	} wr_state_e;

	typedef enum logic [1:0] {
		rd_idle,
		rd_addr,
		rd_data,
		rd_done
	} rd_state_e;

endpackage

// File: src/sbus_region_decode.sv
`timescale 1ns/1ns

module sbus_region_decode
	import sbus_axi_pkg::*;
(
	input  logic [addr_w-1:0] mem_address,
	input  logic [match_id_w-1:0] match_id,
	output logic [addr_w-1:0] remap_addr,
	output logic [id_w-1:0] axi_id
);

	logic [3:0] nib;
	region_e region;

	assign nib = mem_address[addr_w-1 -: 4];

	// two nibbles share the memory region
	always_comb begin
		case (nib)
			region_mem0_nib,
			region_mem1_nib: region = region_mem;
			region_timer_nib: region = region_timer;
			region_gpio_nib: region = region_gpio;
			default: region = region_none;
		endcase
	end

	// peripherals see an offset from their own base
	assign remap_addr = {4'h0, mem_address[addr_w-5:0]};

	// requester in the upper bits, region below
	assign axi_id = {match_id, region};

endmodule

// File: tests/sbus2axi_props.sv
`timescale 1ns/1ns

module sbus2axi_props (
	input logic aclk,
	input logic arst_n,
	input logic awvalid,
	input logic awready,
	input logic [31:0] awaddr,
	input logic [5:0] awid,
	input logic [3:0] awlen,
	input logic wvalid,
	input logic wready,
	input logic [31:0] wdata,
	input logic arvalid,
	input logic arready,
	input logic [31:0] araddr,
	input logic [5:0] arid,
	input logic [3:0] arlen,
	input logic mem_data_ok
);

	int fails = 0;

	// stalled channels keep valid and payload
	aw_hold: assert property (@(posedge aclk) disable iff (!arst_n)
		awvalid && !awready |=> awvalid && $stable(awaddr) && $stable(awid))
		else begin
			$error("aw");
			fails++;
		end
	w_hold: assert property (@(posedge aclk) disable iff (!arst_n)
		wvalid && !wready |=> wvalid && $stable(wdata))
		else begin
			$error("w");
			fails++;
		end
	ar_hold: assert property (@(posedge aclk) disable iff (!arst_n)
		arvalid && !arready |=> arvalid && $stable(araddr) && $stable(arid))
		else begin
			$error("ar");
			fails++;
		end

	single_beat: assert property (@(posedge aclk) awlen == 4'd0 && arlen == 4'd0)
		else begin
			$error("len");
			fails++;
		end
	quiet_reset: assert property (@(posedge aclk) !arst_n |-> !mem_data_ok)
		else begin
			$error("data_ok in reset");
			fails++;
		end

endmodule

bind sbus2axi sbus2axi_props u_props (.*);

// File: tests/tb_sbus2axi.sv
`timescale 1ns/1ns

module tb_sbus2axi
	import sbus_axi_pkg::*;
;

	localparam int timeout_cycles = 2000;

	logic aclk = 1'b0;
	logic arst_n = 1'b0;
	logic mem_req, mem_wen, mem_ren, mem_data_resp;
	logic [addr_w-1:0] mem_address;
	logic [data_w-1:0] mem_wdata;
	logic [strb_w-1:0] mem_wmask;
	logic [2:0] mem_size;
	logic [match_id_w-1:0] match_id;
	logic mem_addr_ok, mem_data_ok, mem_err, writing;
	logic [data_w-1:0] mem_rdata;
	logic [addr_w-1:0] last_write_address, awaddr, araddr;
	logic [3:0] awlen, arlen;
	logic [2:0] awsize, arsize;
	logic [1:0] awburst, arburst;
	logic [id_w-1:0] awid, wid, arid;
	logic awvalid, wvalid, arvalid, bready, rready, wlast;
	logic [data_w-1:0] wdata;
	logic [strb_w-1:0] wstrb;
	logic awready = 1'b0, wready = 1'b0, arready = 1'b0;
	logic bvalid = 1'b0, rvalid = 1'b0, rlast = 1'b0;
	logic [1:0] bresp = 2'b00, rresp = 2'b00;
	logic [id_w-1:0] bid = '0, rid = '0;
	logic [data_w-1:0] rdata = '0;

	integer seed = 32'h9acb_59e4;
	int errors = 0;
	int test_errors = 0;
	int b_seen = 0;
	int w_taken = 0;
	bit rand_resp = 1'b0;
	logic [data_w-1:0] slave_mem [256];
	logic [data_w-1:0] shadow [256];
	bit exp_w_err [$];
	bit exp_r_err [$];
	logic [data_w-1:0] exp_r_data [$];
	logic [7:0] pend_w_idx, pend_r_idx;
	logic [addr_w-1:0] exp_awaddr, exp_araddr, exp_lwa;
	logic [id_w-1:0] exp_awid, exp_arid;
	logic [2:0] exp_awsize, exp_arsize;
	logic [data_w-1:0] exp_wdata;
	logic [strb_w-1:0] exp_wstrb;
	bit exp_writing;

	sbus2axi #(.addr_w(addr_w), .data_w(data_w), .id_w(id_w)) DUT (.*);

	always #10 aclk = ~aclk;

	// ====================
	// reference model
	// ====================
	function automatic logic [2:0] region_of(input logic [3:0] nib);
		case (nib)
			4'h0, 4'h1: return 3'b001;
			4'h2: return 3'b011;
			4'h4: return 3'b111;
			default: return 3'b000;
		endcase
	endfunction

	function automatic logic [data_w-1:0] merge_word(input logic [data_w-1:0] old,
			input logic [data_w-1:0] d, input logic [strb_w-1:0] m);
		logic [data_w-1:0] r;
		r = old;
		for (int b = 0; b < strb_w; b++)
			if (m[b])
				r[b*8 +: 8] = d[b*8 +: 8];
		return r;
	endfunction

	function automatic logic [data_w-1:0] init_word(input int i);
		return 32'h5a00_c300 ^ (i * 32'h0101_0101);
	endfunction

	task automatic check_value(input string name, input logic [31:0] exp, input logic [31:0] act);
		assert (exp === act) else begin
			$display("Mismatch at %0t: %s expected %h got %h", $time, name, exp, act);
			errors++;
		end
	endtask

	task automatic give_up(input string what);
		$display("timeout at %0t while waiting for %s", $time, what);
		$display("FAIL: see errors above");
		$finish;
	endtask

	// ====================
	// axi slave model
	// ====================
	logic [1:0] aw_cnt, w_cnt, ar_cnt;
	bit aw_got, w_got, r_pend;
	logic [addr_w-1:0] aw_a, ar_a;
	logic [id_w-1:0] aw_i, ar_i;
	logic [data_w-1:0] w_d;
	logic [strb_w-1:0] w_s;

	always @(posedge aclk or negedge arst_n) begin
		if (!arst_n) begin
			awready <= 0;
			wready <= 0;
			arready <= 0;
			bvalid <= 0;
			rvalid <= 0;
			aw_cnt <= 0;
			w_cnt <= 0;
			ar_cnt <= 0;
			aw_got <= 0;
			w_got <= 0;
			r_pend <= 0;
		end else begin
			if (awvalid && awready) begin
				awready <= 0;
				aw_got <= 1;
				aw_a <= awaddr;
				aw_i <= awid;
				aw_cnt <= $random(seed) & 3;
				check_value("awaddr", exp_awaddr, awaddr);
				check_value("awid", exp_awid, awid);
				check_value("awsize", exp_awsize, awsize);
				check_value("awburst", 2'b01, awburst);
			end else if (awvalid) begin
				if (aw_cnt == 0) awready <= 1;
				else aw_cnt <= aw_cnt - 1;
			end
			if (wvalid && wready) begin
				wready <= 0;
				w_got <= 1;
				w_d <= wdata;
				w_s <= wstrb;
				w_cnt <= $random(seed) & 3;
				check_value("wdata", exp_wdata, wdata);
				check_value("wstrb", exp_wstrb, wstrb);
				check_value("wlast", 1'b1, wlast);
				check_value("wid", exp_awid, wid);
			end else if (wvalid) begin
				if (w_cnt == 0) wready <= 1;
				else w_cnt <= w_cnt - 1;
			end
			if (aw_got && w_got && !bvalid) begin
				aw_got <= 0;
				w_got <= 0;
				bvalid <= 1;
				bid <= aw_i;
				bresp <= (aw_i[2:0] == 3'b000) ? 2'b10 : 2'b00;
				if (aw_i[2:0] != 3'b000)
					slave_mem[aw_a[9:2]] <= merge_word(slave_mem[aw_a[9:2]], w_d, w_s);
			end else if (bvalid && bready) begin
				bvalid <= 0;
				b_seen <= b_seen + 1;
			end
			if (arvalid && arready) begin
				arready <= 0;
				r_pend <= 1;
				ar_a <= araddr;
				ar_i <= arid;
				ar_cnt <= $random(seed) & 3;
				check_value("araddr", exp_araddr, araddr);
				check_value("arid", exp_arid, arid);
				check_value("arsize", exp_arsize, arsize);
				check_value("arburst", 2'b01, arburst);
			end else if (arvalid) begin
				if (ar_cnt == 0) arready <= 1;
				else ar_cnt <= ar_cnt - 1;
			end
			if (r_pend && !rvalid) begin
				r_pend <= 0;
				rvalid <= 1;
				rlast <= 1;
				rid <= ar_i;
				rresp <= (ar_i[2:0] == 3'b000) ? 2'b10 : 2'b00;
				rdata <= (ar_i[2:0] == 3'b000) ? '0 : slave_mem[ar_a[9:2]];
			end else if (rvalid && rready)
				rvalid <= 0;
		end
	end

	always @(posedge aclk)
		mem_data_resp <= rand_resp ? (($random(seed) & 1) != 0) : 1'b1;

	// ====================
	// compare process
	// ====================
	always @(posedge aclk) begin
		if (arst_n) begin
			check_value("writing", exp_writing, writing);
			check_value("last_write_address", exp_lwa, last_write_address);
			if (mem_req && mem_wen && mem_addr_ok) begin
				exp_writing = 1;
				exp_lwa = {4'h0, mem_address[27:0]};
			end
			if (mem_data_ok && mem_data_resp) begin
				// a write whose B handshake is done must complete first
				if (b_seen != w_taken) begin
					w_taken++;
					exp_writing = 0;
					assert (exp_w_err.size() != 0) else begin
						$display("write completion with no write outstanding at %0t", $time);
						errors++;
					end
					if (exp_w_err.size() != 0)
						check_value("mem_err (write)", exp_w_err.pop_front(), mem_err);
				end else begin
					assert (exp_r_err.size() != 0) else begin
						$display("read completion with no read outstanding at %0t", $time);
						errors++;
					end
					if (exp_r_err.size() != 0) begin
						if (!exp_r_err[0])
							check_value("mem_rdata", exp_r_data[0], mem_rdata);
						check_value("mem_err (read)", exp_r_err.pop_front(), mem_err);
						void'(exp_r_data.pop_front());
					end
				end
			end
		end
	end

	// ====================
	// memory bus driver
	// ====================
	task automatic wait_quiet();
		int n;
		n = 0;
		while (exp_w_err.size() != 0 || exp_r_err.size() != 0) begin
			@(posedge aclk);
			if (++n > timeout_cycles) give_up("outstanding completions");
		end
	endtask

	task automatic issue(input bit wen, input logic [31:0] a, input logic [31:0] d,
			input logic [3:0] m, input logic [2:0] sz, input logic [2:0] mid);
		int n;
		bit bad;
		n = 0;
		// no hazard check in the bridge, so keep same-word accesses apart
		while ((exp_r_err.size() != 0 && pend_r_idx == a[9:2]) ||
				(exp_w_err.size() != 0 && pend_w_idx == a[9:2])) begin
			@(posedge aclk);
			if (++n > timeout_cycles) give_up("a same-address access to finish");
		end
		@(posedge aclk);
		mem_req <= 1;
		mem_wen <= wen;
		mem_ren <= !wen;
		mem_address <= a;
		mem_wdata <= d;
		mem_wmask <= m;
		mem_size <= sz;
		match_id <= mid;
		n = 0;
		do begin
			@(posedge aclk);
			if (++n > timeout_cycles) give_up("mem_addr_ok");
		end while (!mem_addr_ok);
		mem_req <= 0;
		bad = (region_of(a[31:28]) == 3'b000);
		if (wen) begin
			exp_awaddr = {4'h0, a[27:0]};
			exp_awid = {mid, region_of(a[31:28])};
			exp_awsize = sz;
			exp_wdata = d;
			exp_wstrb = m;
			pend_w_idx = a[9:2];
			if (!bad) shadow[a[9:2]] = merge_word(shadow[a[9:2]], d, m);
			exp_w_err.push_back(bad);
		end else begin
			exp_araddr = {4'h0, a[27:0]};
			exp_arid = {mid, region_of(a[31:28])};
			exp_arsize = sz;
			pend_r_idx = a[9:2];
			exp_r_data.push_back(shadow[a[9:2]]);
			exp_r_err.push_back(bad);
		end
	endtask

	task automatic end_test(input string name);
		wait_quiet();
		$display("test %s: %s (%0d errors)", name,
			(errors == test_errors) ? "ok" : "failed", errors - test_errors);
		test_errors = errors;
	endtask

	initial begin
		logic [3:0] nibs [4];
		logic [31:0] a;
		int r;
		nibs = '{4'h0, 4'h1, 4'h2, 4'h4};
		mem_req = 0;
		mem_wen = 0;
		mem_ren = 0;
		mem_data_resp = 0;
		mem_address = '0;
		mem_wdata = '0;
		mem_wmask = '0;
		mem_size = '0;
		match_id = '0;
		exp_writing = 0;
		exp_lwa = '0;
		for (int i = 0; i < 256; i++) begin
			slave_mem[i] = init_word(i);
			shadow[i] = init_word(i);
		end
		repeat (5) @(posedge aclk);
		arst_n <= 1;

		for (int sz = 0; sz < 3; sz++)
			foreach (nibs[k]) begin
				a = 32'h0000_0040 + (sz * 16 + k) * 4;
				issue(1, a, $random(seed), 4'hf >> k, sz, 3'd1);
				issue(1, a, $random(seed), 4'b0110 << (k % 3), sz, 3'd2);
				issue(0, a, 0, 0, sz, 3'd3);
			end
		end_test("masked write and read");

		foreach (nibs[k]) begin
			a = {nibs[k], 28'h0abc_d00} + k * 4;
			issue(1, a, $random(seed), 4'hf, 3'd2, k[2:0] + 3'd4);
			issue(0, a, 0, 0, 3'd2, k[2:0] + 3'd1);
		end
		end_test("region decode and id");

		rand_resp <= 1;
		for (int t = 0; t < 40; t++) begin
			r = $random(seed);
			a = {nibs[r[1:0]], 20'h0, 2'b00, r[7:4], 2'b00};
			issue(r[8], a, $random(seed), r[12:9], 3'd2, r[15:13]);
		end
		end_test("random mixed traffic");
		rand_resp <= 0;

		issue(1, 32'hf000_0100, 32'hdead_beef, 4'hf, 3'd2, 3'd5);
		issue(0, 32'hf000_0100, 0, 0, 3'd2, 3'd5);
		issue(1, 32'h1000_0100, 32'h1234_5678, 4'hf, 3'd2, 3'd5);
		issue(0, 32'h1000_0100, 0, 0, 3'd2, 3'd5);
		end_test("unmapped region");

		issue(1, 32'h4000_0200, 32'h0f0f_0f0f, 4'h3, 3'd1, 3'd6);
		end_test("writing flag and last write address");

		for (int t = 0; t < 6; t++) begin
			issue(1, 32'h0000_0300 + t * 4, $random(seed), 4'hf, 3'd2, 3'd7);
			issue(0, 32'h0000_0380 + t * 4, 0, 0, 3'd2, 3'd7);
		end
		end_test("read beside outstanding write");

		repeat (5) @(posedge aclk);
		// bound handshake properties count toward the total
		errors += DUT.u_props.fails;
		$display("checks done, %0d errors", errors);
		if (errors == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule
